// File: list.f
norm_pkg.sv
step_counter.sv
square_sum.sv
isqrt_serial.sv
div_serial.sv
norm_ctrl_fsm.sv
norm_top.sv
norm_checker.sv
norm_scoreboard.sv
tb_norm.sv

// File: tb_norm.sv
`timescale 1ns/100ps

module tb_norm
    import norm_pkg::*;
();

    localparam int ACCEPT_LIMIT = 50;
    // 115 cycles nominal
    localparam int DONE_LIMIT   = 400;

    logic      clk;
    logic      rst_n;
    logic      data_valid;
    vec_t      vec_in;
    logic      read_done;
    logic      ready;
    logic      calc_done;
    norm_vec_t vec_out;
    int        sb_errors;
    int        sb_checked;
    int        timeouts;

    norm_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .vec_in     (vec_in),
        .read_done  (read_done),
        .ready      (ready),
        .calc_done  (calc_done),
        .vec_out    (vec_out)
    );

    norm_scoreboard sb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .ready      (ready),
        .vec_in     (vec_in),
        .calc_done  (calc_done),
        .read_done  (read_done),
        .vec_out    (vec_out),
        .errors     (sb_errors),
        .checked    (sb_checked)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic finish_run();
        int asserts;
        asserts = dut_i.chk_i.fail_count;
        $display("results %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
                 sb_checked, sb_errors, asserts, timeouts);
        if (sb_errors == 0 && asserts == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // extremes come up about one time in four
    function automatic comp_t rand_comp();
        int sel;
        sel = $urandom_range(0, 7);
        if (sel == 0) begin
            return comp_t'(-32768);
        end
        if (sel == 1) begin
            return comp_t'(32767);
        end
        return comp_t'($urandom);
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        v.x = rand_comp();
        v.y = rand_comp();
        v.z = rand_comp();
        return v;
    endfunction

    function automatic vec_t make_vec(int x, int y, int z);
        vec_t v;
        v.x = comp_t'(x);
        v.y = comp_t'(y);
        v.z = comp_t'(z);
        return v;
    endfunction

    // called on a falling edge
    task automatic run_vector(vec_t v, int read_delay, bit poke);
        int cnt;
        // nothing more is sent once the DUT has stalled
        if (timeouts != 0) begin
            return;
        end
        data_valid = 1'b1;
        vec_in     = v;
        cnt = 0;
        while (!ready && cnt < ACCEPT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ready) begin
            timed_out("ready did not come back high");
            return;
        end
        // accepted on the rising edge just passed
        @(negedge clk);
        data_valid = 1'b0;
        vec_in     = rand_vec();
        if (poke) begin
            // valid while busy is ignored
            repeat (2) begin
                data_valid = 1'b1;
                vec_in     = rand_vec();
                @(negedge clk);
                data_valid = 1'b0;
                @(negedge clk);
            end
        end
        cnt = 0;
        while (!calc_done && cnt < DONE_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!calc_done) begin
            timed_out("calc_done never rose");
            return;
        end
        repeat (read_delay) @(negedge clk);
        read_done = 1'b1;
        @(negedge clk);
        read_done = 1'b0;
    endtask

    initial begin
        void'($urandom(46));
        clk        = 1'b0;
        rst_n      = 1'b0;
        data_valid = 1'b0;
        vec_in     = '0;
        read_done  = 1'b0;
        timeouts   = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // single axis vectors
        run_vector(make_vec(0, 5000, 0), 0, 1'b0);
        run_vector(make_vec(-300, 0, 0), 3, 1'b0);
        run_vector(make_vec(0, 0, -32768), 0, 1'b0);
        run_vector(make_vec(0, 0, 32767), 1, 1'b0);
        // zero vector takes the short path
        run_vector(make_vec(0, 0, 0), 5, 1'b1);
        // long read delay and a busy poke
        run_vector(make_vec(1200, -1200, 7), 40, 1'b1);

        for (int i = 0; i < 200; i++) begin
            run_vector(rand_vec(), $urandom_range(0, 40), $urandom_range(0, 3) == 0);
        end

        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// File: norm_scoreboard.sv
`timescale 1ns/100ps

module norm_scoreboard
    import norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      data_valid,
    input  logic      ready,
    input  vec_t      vec_in,
    input  logic      calc_done,
    input  logic      read_done,
    input  norm_vec_t vec_out,
    output int        errors,
    output int        checked
);

    // expected results of accepted vectors, oldest first
    norm_vec_t exp_q[$];
    norm_vec_t cur_exp;
    logic      done_q;

    // largest r with r*r <= s
    function automatic longint floor_sqrt(longint s);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 65536;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= s) begin
                lo = mid;
            end else begin
                hi = mid - 1;
            end
        end
        return lo;
    endfunction

    // |c| << FRAC_W over mag, truncated, sign put back
    function automatic frac_t scale(comp_t c, longint mag);
        longint a;
        longint q;
        a = c;
        if (a < 0) begin
            a = -a;
        end
        q = (a << FRAC_W) / mag;
        if (c < 0) begin
            q = -q;
        end
        return frac_t'(q);
    endfunction

    function automatic norm_vec_t norm_ref(vec_t v);
        comp_t     c[3];
        longint    s;
        longint    mag;
        norm_vec_t r;
        c[0] = v.x;
        c[1] = v.y;
        c[2] = v.z;
        s = 0;
        for (int i = 0; i < 3; i++) begin
            s += longint'(c[i]) * longint'(c[i]);
        end
        // zero vector maps to zero
        if (s == 0) begin
            return '0;
        end
        mag = floor_sqrt(s);
        r.x = scale(c[0], mag);
        r.y = scale(c[1], mag);
        r.z = scale(c[2], mag);
        return r;
    endfunction

    task automatic compare_axis(string name, frac_t got, frac_t want);
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic compare_vec(norm_vec_t got, norm_vec_t want);
        compare_axis("x", got.x, want.x);
        compare_axis("y", got.y, want.y);
        compare_axis("z", got.z, want.z);
    endtask

    initial begin
        errors  = 0;
        checked = 0;
        done_q  = 1'b0;
        cur_exp = '0;
    end

    // pre-edge values, outputs settled since the last edge
    always @(posedge clk) begin
        if (!rst_n) begin
            done_q = 1'b0;
            exp_q.delete();
        end else begin
            if (data_valid && ready) begin
                exp_q.push_back(norm_ref(vec_in));
            end
            if (calc_done && !done_q) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("result at %0t without an accepted vector", $time);
                end else begin
                    cur_exp = exp_q.pop_front();
                    compare_vec(vec_out, cur_exp);
                    checked++;
                end
            end else if (calc_done && read_done) begin
                // value at the read still the same
                compare_vec(vec_out, cur_exp);
            end
            done_q = calc_done;
        end
    end

endmodule

// File: norm_checker.sv
`timescale 1ns/100ps

module norm_checker
    import norm_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      ready,
    input logic      calc_done,
    input logic      read_done,
    input norm_vec_t vec_out
);

    // failed assertions, read by the testbench top
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // input and result handshakes never overlap
    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ready && calc_done))
        else begin
            fail_count++;
            $error("ready and calc_done high together");
        end

    // result held until the master reads it
    a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
        calc_done && !read_done |=> calc_done)
        else begin
            fail_count++;
            $error("calc_done dropped before read_done");
        end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        calc_done |=> $stable(vec_out))
        else begin
            fail_count++;
            $error("vec_out changed while calc_done high");
        end

    // first cycle out of reset
    a_reset_ready: assert property (@(posedge clk)
        $rose(rst_n) |-> ready && !calc_done)
        else begin
            fail_count++;
            $error("ready low or calc_done high after reset");
        end

endmodule

bind norm_top norm_checker chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready     (ready),
    .calc_done (calc_done),
    .read_done (read_done),
    .vec_out   (vec_out)
);

// File: norm_top.sv
`timescale 1ns/100ps

module norm_top
    import norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      data_valid,
    input  vec_t      vec_in,
    input  logic      read_done,
    output logic      ready,
    output logic      calc_done,
    output norm_vec_t vec_out
);

    // controller strobes
    logic  capture;
    logic  cnt_load;
    step_t cnt_len;
    logic  last;
    logic  sq_step;
    logic  sqrt_start;
    logic  sqrt_step;
    logic  div_start;
    logic  div_step;
    axis_t axis;
    logic  clear;

    // datapath results
    vec_t   vec;
    sumsq_t sum;
    logic   sum_zero;
    mag_t   mag;

    norm_ctrl_fsm ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_valid (data_valid),
        .read_done  (read_done),
        .sum_zero   (sum_zero),
        .last       (last),
        .ready      (ready),
        .calc_done  (calc_done),
        .capture    (capture),
        .cnt_load   (cnt_load),
        .cnt_len    (cnt_len),
        .sq_step    (sq_step),
        .sqrt_start (sqrt_start),
        .sqrt_step  (sqrt_step),
        .div_start  (div_start),
        .div_step   (div_step),
        .axis       (axis),
        .clear      (clear)
    );

    // one counter times every serial phase
    step_counter cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (cnt_load),
        .len   (cnt_len),
        .last  (last)
    );

    square_sum sq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .step     (sq_step),
        .vec_in   (vec_in),
        .vec      (vec),
        .sum      (sum),
        .sum_zero (sum_zero)
    );

    isqrt_serial sqrt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (sqrt_start),
        .step  (sqrt_step),
        .sum   (sum),
        .mag   (mag)
    );

    div_serial div_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (div_start),
        .step    (div_step),
        .clear   (clear),
        .axis    (axis),
        .vec     (vec),
        .mag     (mag),
        .vec_out (vec_out)
    );

endmodule

// File: norm_ctrl_fsm.sv
`timescale 1ns/100ps

module norm_ctrl_fsm
    import norm_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  data_valid,
    input  logic  read_done,
    input  logic  sum_zero,
    input  logic  last,
    output logic  ready,
    output logic  calc_done,
    output logic  capture,
    output logic  cnt_load,
    output step_t cnt_len,
    output logic  sq_step,
    output logic  sqrt_start,
    output logic  sqrt_step,
    output logic  div_start,
    output logic  div_step,
    output axis_t axis,
    output logic  clear
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    axis_t       axis_q;
    axis_t       axis_next;
    // high in the start cycle of SQRT and of each division
    logic        first;
    logic        first_next;

    // handshake levels decoded straight from the state
    assign ready     = (state == IDLE);
    assign calc_done = (state == DONE);
    assign capture   = ready && data_valid;

    assign sq_step    = (state == SQUARE);
    assign sqrt_start = (state == SQRT) && first;
    assign sqrt_step  = (state == SQRT) && !first;
    assign div_start  = (state == DIVIDE) && first;
    assign div_step   = (state == DIVIDE) && !first;
    assign axis       = axis_q;

    // sum is final in the sqrt start cycle, zero vector bails out here
    assign clear = sqrt_start && sum_zero;

    // counter loaded on acceptance and in every start cycle
    assign cnt_load = capture || sqrt_start || div_start;

    always_comb begin
        case (state)
            IDLE:    cnt_len = SQUARE_STEPS;
            SQRT:    cnt_len = SQRT_STEPS;
            default: cnt_len = DIV_STEPS;
        endcase
    end

    always_comb begin
        state_next = state;
        axis_next  = axis_q;
        first_next = 1'b0;
        case (state)
            IDLE: begin
                if (capture) begin
                    state_next = SQUARE;
                end
            end
            SQUARE: begin
                if (last) begin
                    state_next = SQRT;
                    first_next = 1'b1;
                end
            end
            SQRT: begin
                if (first && sum_zero) begin
                    state_next = DONE;
                end else if (!first && last) begin
                    state_next = DIVIDE;
                    axis_next  = X;
                    first_next = 1'b1;
                end
            end
            DIVIDE: begin
                // next axis gets its own start cycle
                if (!first && last) begin
                    first_next = 1'b1;
                    case (axis_q)
                        X: axis_next = Y;
                        Y: axis_next = Z;
                        default: begin
                            state_next = DONE;
                            first_next = 1'b0;
                        end
                    endcase
                end
            end
            DONE: begin
                // hold result until the master has read it
                if (read_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            axis_q <= X;
            first  <= 1'b0;
        end else begin
            state  <= state_next;
            axis_q <= axis_next;
            first  <= first_next;
        end
    end

endmodule

// File: div_serial.sv
`timescale 1ns/100ps

module div_serial
    import norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      step,
    input  logic      clear,
    input  axis_t     axis,
    input  vec_t      vec,
    input  mag_t      mag,
    output norm_vec_t vec_out
);

    localparam int Q_W = DIV_STEPS;

    comp_t             comp;
    logic [COMP_W-1:0] comp_abs;
    // dividend bits, shifted out from the top
    logic [Q_W-1:0]    dvd;
    // quotient bits above a one-hot marker
    logic [Q_W-1:0]    quo;
    logic [Q_W-1:0]    quo_next;
    mag_t              rem;
    logic [COMP_W+1:0] trial;
    logic              fits;
    logic              neg;
    logic              last_step;
    frac_t             result;

    always_comb begin
        case (axis)
            X:       comp = vec.x;
            Y:       comp = vec.y;
            default: comp = vec.z;
        endcase
    end

    // -32768 maps to 0x8000, still correct as unsigned
    assign comp_abs = comp[COMP_W-1] ? COMP_W'(-comp) : COMP_W'(comp);

    assign trial    = {rem, dvd[Q_W-1]};
    assign fits     = (trial >= {1'b0, mag});
    assign quo_next = {quo[Q_W-2:0], fits};
    // marker reaches the top during the final step
    assign last_step = quo[Q_W-1];

    // quotient never above 1 << FRAC_W since mag >= |comp|
    assign result = neg ? frac_t'(-quo_next[COMP_W-1:0]) : frac_t'(quo_next[COMP_W-1:0]);

    always_ff @(posedge clk) begin
        if (start) begin
            dvd <= {comp_abs, {FRAC_W{1'b0}}};
            quo <= Q_W'(1);
            rem <= '0;
            neg <= comp[COMP_W-1];
        end else if (step) begin
            dvd <= dvd << 1;
            quo <= quo_next;
            if (fits) begin
                rem <= mag_t'(trial - {1'b0, mag});
            end else begin
                rem <= mag_t'(trial);
            end
        end
    end

    // result register, one field per division
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_out <= '0;
        end else if (clear) begin
            vec_out <= '0;
        end else if (step && last_step) begin
            case (axis)
                X:       vec_out.x <= result;
                Y:       vec_out.y <= result;
                default: vec_out.z <= result;
            endcase
        end
    end

endmodule

// File: isqrt_serial.sv
`timescale 1ns/100ps

module isqrt_serial
    import norm_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   step,
    input  sumsq_t sum,
    output mag_t   mag
);

    // remainder stays below 2*root+1
    localparam int REM_W = COMP_W + 3;
    localparam int SUM_W = $bits(sumsq_t);

    // radicand, consumed two bits per step from the top
    sumsq_t           rad;
    logic [REM_W-1:0] rem;
    mag_t             root;
    logic [REM_W+1:0] trial;
    logic [REM_W+1:0] sub;
    logic             fits;

    // bring down the next bit pair
    assign trial = {rem, rad[SUM_W-1 -: 2]};
    // 4*root + 1
    assign sub   = {2'b00, root, 2'b01};
    assign fits  = (trial >= sub);

    always_ff @(posedge clk) begin
        if (start) begin
            rad <= sum;
        end else if (step) begin
            rad <= rad << 2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rem  <= '0;
            root <= '0;
        end else if (start) begin
            rem  <= '0;
            root <= '0;
        end else if (step) begin
            // restoring step, keep remainder when the trial does not fit
            if (fits) begin
                rem <= REM_W'(trial - sub);
            end else begin
                rem <= REM_W'(trial);
            end
            root <= {root[COMP_W-1:0], fits};
        end
    end

    // floor of sqrt(sum) once all pairs are in
    assign mag = root;

endmodule

// File: square_sum.sv
`timescale 1ns/100ps

module square_sum
    import norm_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   capture,
    input  logic   step,
    input  vec_t   vec_in,
    output vec_t   vec,
    output sumsq_t sum,
    output logic   sum_zero
);

    vec_t   vec_q;
    sumsq_t acc;
    // component squared on the next step
    axis_t  idx;
    comp_t  sel;
    logic signed [2*COMP_W-1:0] square;

    always_comb begin
        case (idx)
            X:       sel = vec_q.x;
            Y:       sel = vec_q.y;
            default: sel = vec_q.z;
        endcase
    end

    // single shared multiplier, result never negative
    assign square = sel * sel;

    // vector held for the divider
    always_ff @(posedge clk) begin
        if (capture) begin
            vec_q <= vec_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            idx <= X;
        end else if (capture) begin
            acc <= '0;
            idx <= X;
        end else if (step) begin
            acc <= acc + {2'b00, square};
            case (idx)
                X:       idx <= Y;
                Y:       idx <= Z;
                default: idx <= X;
            endcase
        end
    end

    assign vec = vec_q;
    assign sum = acc;
    // zero only for the zero vector
    assign sum_zero = (acc == '0);

endmodule

// File: step_counter.sv
`timescale 1ns/100ps

module step_counter
    import norm_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,
    input  step_t len,
    output logic  last
);

    step_t count;
    // counting a phase
    logic  busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (load) begin
            // first step is the cycle after the load
            count <= step_t'(len - 1'b1);
            busy  <= 1'b1;
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // final step of the running phase
    assign last = busy && (count == '0);

endmodule

// File: norm_pkg.sv
package norm_pkg;

    // input component width, signed integer
    localparam int COMP_W = 16;
    // fraction bits of a normalized result, 1.0 == 1 << FRAC_W
    localparam int FRAC_W = 14;

    typedef logic signed [COMP_W-1:0] comp_t;
    // normalized component, range -1.0 .. +1.0
    typedef logic signed [COMP_W-1:0] frac_t;
    // x*x + y*y + z*z, worst case 3 * 2^30
    typedef logic [2*COMP_W+1:0]      sumsq_t;
    // floor(sqrt(sum)), one bit per radicand pair
    typedef logic [COMP_W:0]          mag_t;
    typedef logic [5:0]               step_t;

    typedef struct packed {
        comp_t x;
        comp_t y;
        comp_t z;
    } vec_t;

    typedef struct packed {
        frac_t x;
        frac_t y;
        frac_t z;
    } norm_vec_t;

    // component selected for squaring or division
    typedef enum logic [1:0] {X, Y, Z} axis_t;

    typedef enum logic [2:0] {IDLE, SQUARE, SQRT, DIVIDE, DONE} ctrl_state_t;

    // steps per serial phase
    localparam step_t SQUARE_STEPS = step_t'(3);
    localparam step_t SQRT_STEPS   = step_t'(COMP_W + 1);
    localparam step_t DIV_STEPS    = step_t'(COMP_W + FRAC_W);

endpackage
